/* design/alu.sv */
module alu (
	input  isa_pkg::opcode_e op,
	input  logic [cpu_cfg_pkg::word_w-1:0] in_a,
	input  logic [cpu_cfg_pkg::word_w-1:0] in_b,
	output logic [cpu_cfg_pkg::word_w-1:0] result,
	output logic [2:0] flags_new,
	output logic [2:0] flags_we
);
	import cpu_cfg_pkg::*;
	import isa_pkg::*;

	logic [word_w-1:0] sum;
	logic [word_w-1:0] diff;
	logic [word_w-1:0] sat;      // Clamp value on overflow
	logic [2*word_w-1:0] rot;
	logic [3:0] amt;
	logic ovf_add;
	logic ovf_sub;
	logic ovf;

	assign amt  = in_b[3:0];
	assign sum  = in_a + in_b;
	assign diff = in_a - in_b;
	assign rot  = {in_a, in_a} >> amt; // Low half is the rotate right
	// Same-sign operands, result sign flipped
	assign ovf_add = (in_a[word_w-1] == in_b[word_w-1]) && (sum[word_w-1] != in_a[word_w-1]);
	assign ovf_sub = (in_a[word_w-1] != in_b[word_w-1]) && (diff[word_w-1] != in_a[word_w-1]);
	// Saturate toward the sign of in_a
	assign sat = in_a[word_w-1] ? {1'b1, {(word_w-1){1'b0}}} : {1'b0, {(word_w-1){1'b1}}};

	always_comb begin
		result   = '0;
		ovf      = 1'b0;
		flags_we = 3'b000;
		case (op)
			op_add: begin
				result   = ovf_add ? sat : sum;
				ovf      = ovf_add;
				flags_we = 3'b111;
			end
			op_sub: begin
				result   = ovf_sub ? sat : diff;
				ovf      = ovf_sub;
				flags_we = 3'b111;
			end
			op_xor: result = in_a ^ in_b;
			op_and: result = in_a & in_b;
			op_or:  result = in_a | in_b;
			op_sll: result = in_a << amt;
			op_sra: result = $signed(in_a) >>> amt; // Sign fill
			op_ror: result = rot[word_w-1:0];
			default: result = '0;                  // Not an ALU op
		endcase
		if (op <= op_or)
			flags_we[flag_z] = 1'b1; // Every ALU op updates Z
	end

	assign flags_new[flag_z] = (result == '0);
	assign flags_new[flag_v] = ovf;
	assign flags_new[flag_n] = result[word_w-1];

endmodule

/* design/cpu.sv */
module cpu (
	input  logic clk,
	input  logic reset,
	output logic [cpu_cfg_pkg::word_w-1:0] imem_addr,
	input  logic [cpu_cfg_pkg::word_w-1:0] imem_data,
	output logic [cpu_cfg_pkg::word_w-1:0] dmem_addr,
	output logic [cpu_cfg_pkg::word_w-1:0] dmem_wdata,
	output logic dmem_we,
	output logic dmem_re,
	input  logic [cpu_cfg_pkg::word_w-1:0] dmem_rdata,
	output logic wb_valid,
	output logic [cpu_cfg_pkg::reg_idx_w-1:0] wb_reg,
	output logic [cpu_cfg_pkg::word_w-1:0] wb_data,
	output logic [cpu_cfg_pkg::word_w-1:0] pc_out,
	output logic hlt
);
	import cpu_cfg_pkg::*;
	import isa_pkg::*;

	// --------------------------------------------------
	// Stage to stage wiring, names match the stage ports
	// --------------------------------------------------
	logic [word_w-1:0] id_pc;          // IF/ID
	instr_u id_instr;
	logic id_valid;
	logic stall;                       // ID to IF
	logic branch_taken;                // EX to IF and ID
	logic [word_w-1:0] branch_target;
	logic [word_w-1:0] ex_pc;          // ID/EX
	instr_u ex_instr;
	logic [word_w-1:0] ex_data_a;
	logic [word_w-1:0] ex_data_b;
	logic [reg_idx_w-1:0] ex_src_a;
	logic [reg_idx_w-1:0] ex_src_b;
	logic [reg_idx_w-1:0] ex_rd;
	logic ex_reg_write;
	logic ex_mem_to_reg;
	logic ex_mem_write;
	logic ex_valid;
	logic ex_halt;
	logic [word_w-1:0] mem_result;     // EX/MEM
	logic [word_w-1:0] mem_addr;
	logic [word_w-1:0] mem_store_data;
	logic [reg_idx_w-1:0] mem_rd;
	logic mem_reg_write;
	logic mem_mem_to_reg;
	logic mem_mem_write;
	logic mem_valid;
	logic mem_halt;
	logic mem_fwd_valid;               // MEM forward into EX
	logic [reg_idx_w-1:0] mem_fwd_reg;
	logic [word_w-1:0] mem_fwd_data;

	fetch_stage i_fetch_stage (.*);

	decode_stage i_decode_stage (.*);

	execute_stage i_execute_stage (.*);

	mem_wb_stage i_mem_wb_stage (.*);

	assign pc_out = imem_addr; // Current fetch address

endmodule

/* design/cpu_cfg_pkg.sv */
package cpu_cfg_pkg;

	// --------------------------------------------------
	// Core widths
	// --------------------------------------------------
	localparam int word_w    = 16; // Data path and address width
	localparam int reg_cnt   = 16; // Architectural registers, r0 reads zero
	localparam int reg_idx_w = 4;  // Register index width

	// Byte address step between instructions
	localparam logic [word_w-1:0] pc_step = 16'd2;

endpackage

/* design/decode_stage.sv */
module decode_stage (
	input  logic clk,
	input  logic reset,
	input  logic [cpu_cfg_pkg::word_w-1:0] id_pc,
	input  isa_pkg::instr_u id_instr,
	input  logic id_valid,
	input  logic branch_taken,
	input  logic wb_valid,
	input  logic [cpu_cfg_pkg::reg_idx_w-1:0] wb_reg,
	input  logic [cpu_cfg_pkg::word_w-1:0] wb_data,
	output logic stall,
	output logic [cpu_cfg_pkg::word_w-1:0] ex_pc,
	output isa_pkg::instr_u ex_instr,
	output logic [cpu_cfg_pkg::word_w-1:0] ex_data_a,
	output logic [cpu_cfg_pkg::word_w-1:0] ex_data_b,
	output logic [cpu_cfg_pkg::reg_idx_w-1:0] ex_src_a,
	output logic [cpu_cfg_pkg::reg_idx_w-1:0] ex_src_b,
	output logic [cpu_cfg_pkg::reg_idx_w-1:0] ex_rd,
	output logic ex_reg_write,
	output logic ex_mem_to_reg,
	output logic ex_mem_write,
	output logic ex_valid,
	output logic ex_halt
);
	import cpu_cfg_pkg::*;
	import isa_pkg::*;

	opcode_e op;
	logic [reg_idx_w-1:0] src_a;
	logic [reg_idx_w-1:0] src_b;
	logic [word_w-1:0] rd_data_a;
	logic [word_w-1:0] rd_data_b;
	logic use_a;
	logic use_b;
	logic writes_rd;
	logic load_use;
	logic is_halt;
	logic halt_sent; // Halt already handed to EX
	logic bubble;

	assign op = id_instr.regs.opcode;

	// --------------------------------------------------
	// Source selection and control decode
	// --------------------------------------------------
	assign src_a = (op inside {op_sw, op_lhb, op_llb}) ? id_instr.regs.rd : id_instr.regs.rs;
	assign src_b = (op inside {op_sw, op_lw}) ? id_instr.regs.rs : id_instr.regs.rt;
	assign use_a = !(op inside {op_lw, op_b, op_pcs, op_hlt});
	assign use_b = op inside {op_add, op_sub, op_xor, op_and, op_or, op_lw, op_sw};
	assign writes_rd = (op <= op_or) || (op inside {op_lw, op_lhb, op_llb, op_pcs});

	// Load in EX feeding a source here needs one bubble
	assign load_use = id_valid && ex_mem_to_reg && ex_reg_write &&
	                  ((use_a && ex_rd == src_a) || (use_b && ex_rd == src_b));
	assign is_halt = id_valid && op == op_hlt;
	assign stall   = load_use || is_halt; // Halt freezes fetch for good
	assign bubble  = branch_taken || load_use || (is_halt && halt_sent);

	register_file i_register_file (
		.clk       (clk),
		.reset     (reset),
		.rd_idx_a  (src_a),
		.rd_idx_b  (src_b),
		.wr_en     (wb_valid),
		.wr_idx    (wb_reg),
		.wr_data   (wb_data),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	always_ff @(posedge clk) begin
		if (reset)
			halt_sent <= 1'b0;
		else if (is_halt && !branch_taken)
			halt_sent <= 1'b1;
	end

	// --------------------------------------------------
	// ID/EX register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset || bubble) begin
			ex_valid      <= 1'b0;
			ex_reg_write  <= 1'b0;
			ex_mem_to_reg <= 1'b0;
			ex_mem_write  <= 1'b0;
			ex_halt       <= 1'b0;
		end else begin
			ex_valid      <= id_valid;
			ex_reg_write  <= id_valid && writes_rd && id_instr.regs.rd != '0; // r0 writes dropped
			ex_mem_to_reg <= id_valid && op == op_lw;
			ex_mem_write  <= id_valid && op == op_sw;
			ex_halt       <= is_halt;
		end
	end

	always_ff @(posedge clk) begin
		ex_pc     <= id_pc;
		ex_instr  <= id_instr;
		ex_data_a <= rd_data_a;
		ex_data_b <= rd_data_b;
		ex_src_a  <= src_a;
		ex_src_b  <= src_b;
		ex_rd     <= id_instr.regs.rd;
	end

endmodule

/* design/execute_stage.sv */
module execute_stage (
	input  logic clk,
	input  logic reset,
	input  logic [cpu_cfg_pkg::word_w-1:0] ex_pc,
	input  isa_pkg::instr_u ex_instr,
	input  logic [cpu_cfg_pkg::word_w-1:0] ex_data_a,
	input  logic [cpu_cfg_pkg::word_w-1:0] ex_data_b,
	input  logic [cpu_cfg_pkg::reg_idx_w-1:0] ex_src_a,
	input  logic [cpu_cfg_pkg::reg_idx_w-1:0] ex_src_b,
	input  logic [cpu_cfg_pkg::reg_idx_w-1:0] ex_rd,
	input  logic ex_reg_write,
	input  logic ex_mem_to_reg,
	input  logic ex_mem_write,
	input  logic ex_valid,
	input  logic ex_halt,
	input  logic mem_fwd_valid,
	input  logic [cpu_cfg_pkg::reg_idx_w-1:0] mem_fwd_reg,
	input  logic [cpu_cfg_pkg::word_w-1:0] mem_fwd_data,
	input  logic wb_valid,
	input  logic [cpu_cfg_pkg::reg_idx_w-1:0] wb_reg,
	input  logic [cpu_cfg_pkg::word_w-1:0] wb_data,
	output logic branch_taken,
	output logic [cpu_cfg_pkg::word_w-1:0] branch_target,
	output logic [cpu_cfg_pkg::word_w-1:0] mem_result,
	output logic [cpu_cfg_pkg::word_w-1:0] mem_addr,
	output logic [cpu_cfg_pkg::word_w-1:0] mem_store_data,
	output logic [cpu_cfg_pkg::reg_idx_w-1:0] mem_rd,
	output logic mem_reg_write,
	output logic mem_mem_to_reg,
	output logic mem_mem_write,
	output logic mem_valid,
	output logic mem_halt
);
	import cpu_cfg_pkg::*;
	import isa_pkg::*;

	opcode_e op;
	logic [word_w-1:0] fwd_a;
	logic [word_w-1:0] fwd_b;
	logic [word_w-1:0] alu_b;
	logic [word_w-1:0] alu_result;
	logic [word_w-1:0] ex_result;
	logic [word_w-1:0] addr;
	logic [2:0] flags;   // Z V N, see isa_pkg positions
	logic [2:0] flags_new;
	logic [2:0] flags_we;
	logic alu_op;
	logic cond_ok;

	assign op     = ex_instr.regs.opcode;
	assign alu_op = (op <= op_or);

	// --------------------------------------------------
	// Forwarding, MEM is younger so it wins
	// --------------------------------------------------
	assign fwd_a = (mem_fwd_valid && mem_fwd_reg == ex_src_a) ? mem_fwd_data :
	               (wb_valid && wb_reg == ex_src_a) ? wb_data : ex_data_a;
	assign fwd_b = (mem_fwd_valid && mem_fwd_reg == ex_src_b) ? mem_fwd_data :
	               (wb_valid && wb_reg == ex_src_b) ? wb_data : ex_data_b;

	// Shifts take the sign-extended rt field as amount
	assign alu_b = (op inside {op_sll, op_sra, op_ror}) ?
	               {{(word_w-4){ex_instr.regs.rt[3]}}, ex_instr.regs.rt} : fwd_b;

	alu i_alu (
		.op        (op),
		.in_a      (fwd_a),
		.in_b      (alu_b),
		.result    (alu_result),
		.flags_new (flags_new),
		.flags_we  (flags_we)
	);

	always_ff @(posedge clk) begin
		if (reset)
			flags <= 3'b000;
		else if (ex_valid && alu_op)
			flags <= (flags & ~flags_we) | (flags_new & flags_we); // Masked update
	end

	always_comb begin
		case (op)
			op_lhb:  ex_result = {ex_instr.bytes.imm, fwd_a[7:0]};
			op_llb:  ex_result = {fwd_a[15:8], ex_instr.bytes.imm};
			op_pcs:  ex_result = ex_pc;        // Already PC+2
			default: ex_result = alu_result;
		endcase
	end

	// Word aligned base plus doubled signed offset
	assign addr = (fwd_b & ~16'h0001) + {{(word_w-5){ex_instr.regs.rt[3]}}, ex_instr.regs.rt, 1'b0};

	// --------------------------------------------------
	// Branch resolution on the current flags
	// --------------------------------------------------
	always_comb begin
		case (ex_instr.branch.cond)
			cc_ne:   cond_ok = !flags[flag_z];
			cc_eq:   cond_ok = flags[flag_z];
			cc_gt:   cond_ok = !flags[flag_z] && !flags[flag_n];
			cc_lt:   cond_ok = flags[flag_n];
			cc_ge:   cond_ok = flags[flag_z] || !flags[flag_n];
			cc_le:   cond_ok = flags[flag_z] || flags[flag_n];
			cc_ov:   cond_ok = flags[flag_v];
			default: cond_ok = 1'b1;                // Unconditional
		endcase
	end

	assign branch_taken  = ex_valid && (op inside {op_b, op_br}) && cond_ok;
	assign branch_target = (op == op_br) ? fwd_a :
	                       ex_pc + {{(word_w-10){ex_instr.branch.offset[8]}},
	                                ex_instr.branch.offset, 1'b0};

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (reset) begin
			mem_valid      <= 1'b0;
			mem_reg_write  <= 1'b0;
			mem_mem_to_reg <= 1'b0;
			mem_mem_write  <= 1'b0;
			mem_halt       <= 1'b0;
		end else begin
			mem_valid      <= ex_valid;
			mem_reg_write  <= ex_reg_write;
			mem_mem_to_reg <= ex_mem_to_reg;
			mem_mem_write  <= ex_mem_write;
			mem_halt       <= ex_halt;
		end
	end

	always_ff @(posedge clk) begin
		mem_result     <= ex_result;
		mem_addr       <= addr;
		mem_store_data <= fwd_a;   // sw data comes from rd
		mem_rd         <= ex_rd;
	end

endmodule

/* design/fetch_stage.sv */
module fetch_stage (
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic branch_taken,
	input  logic [cpu_cfg_pkg::word_w-1:0] branch_target,
	output logic [cpu_cfg_pkg::word_w-1:0] imem_addr,
	input  logic [cpu_cfg_pkg::word_w-1:0] imem_data,
	output logic [cpu_cfg_pkg::word_w-1:0] id_pc,
	output isa_pkg::instr_u id_instr,
	output logic id_valid
);
	import cpu_cfg_pkg::*;

	logic [word_w-1:0] pc;
	logic [word_w-1:0] pc_plus_2;

	assign pc_plus_2 = pc + pc_step;
	assign imem_addr = pc; // Memory answers in the same cycle

	// Branch from EX wins over any stall from ID
	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0;
		else if (branch_taken)
			pc <= branch_target;
		else if (!stall)
			pc <= pc_plus_2;
	end

	// --------------------------------------------------
	// IF/ID register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset || branch_taken) begin
			id_valid <= 1'b0; // Squash the wrong-path fetch
		end else if (!stall) begin
			id_valid <= 1'b1;
			id_pc    <= pc_plus_2;
			id_instr <= imem_data;
		end
	end

endmodule

/* design/isa_pkg.sv */
package isa_pkg;

	// --------------------------------------------------
	// Opcodes, top nibble of every instruction
	// --------------------------------------------------
	typedef enum logic [3:0] {
		op_add = 4'h0, // Saturating add
		op_sub = 4'h1, // Saturating subtract
		op_xor = 4'h2,
		op_and = 4'h3,
		op_sll = 4'h4, // Shifts take a 4-bit immediate
		op_sra = 4'h5,
		op_ror = 4'h6,
		op_or  = 4'h7, // Last ALU opcode
		op_lw  = 4'h8,
		op_sw  = 4'h9,
		op_lhb = 4'hA, // Load high byte, keep low byte of rd
		op_llb = 4'hB, // Load low byte, keep high byte of rd
		op_b   = 4'hC, // PC relative branch
		op_br  = 4'hD, // Branch to register
		op_pcs = 4'hE, // rd gets PC+2
		op_hlt = 4'hF
	} opcode_e;

	// Branch conditions
	typedef enum logic [2:0] {
		cc_ne     = 3'd0,
		cc_eq     = 3'd1,
		cc_gt     = 3'd2,
		cc_lt     = 3'd3,
		cc_ge     = 3'd4,
		cc_le     = 3'd5,
		cc_ov     = 3'd6,
		cc_always = 3'd7
	} cond_e;

	// Flag register bit positions
	localparam int flag_z = 2;
	localparam int flag_v = 1;
	localparam int flag_n = 0;

	// --------------------------------------------------
	// Instruction formats
	// --------------------------------------------------
	typedef struct packed {
		opcode_e    opcode;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;   // Also shift amount and lw/sw offset
	} instr_reg_t;

	typedef struct packed {
		opcode_e    opcode;
		logic [3:0] rd;
		logic [7:0] imm;  // Byte for lhb/llb
	} instr_byte_t;

	typedef struct packed {
		opcode_e    opcode;
		cond_e      cond;
		logic [8:0] offset; // Signed word offset
	} instr_branch_t;

	typedef union packed {
		instr_reg_t    regs;
		instr_byte_t   bytes;
		instr_branch_t branch;
	} instr_u;

endpackage

/* design/mem_wb_stage.sv */
module mem_wb_stage (
	input  logic clk,
	input  logic reset,
	input  logic [cpu_cfg_pkg::word_w-1:0] mem_result,
	input  logic [cpu_cfg_pkg::word_w-1:0] mem_addr,
	input  logic [cpu_cfg_pkg::word_w-1:0] mem_store_data,
	input  logic [cpu_cfg_pkg::reg_idx_w-1:0] mem_rd,
	input  logic mem_reg_write,
	input  logic mem_mem_to_reg,
	input  logic mem_mem_write,
	input  logic mem_valid,
	input  logic mem_halt,
	output logic [cpu_cfg_pkg::word_w-1:0] dmem_addr,
	output logic [cpu_cfg_pkg::word_w-1:0] dmem_wdata,
	output logic dmem_we,
	output logic dmem_re,
	input  logic [cpu_cfg_pkg::word_w-1:0] dmem_rdata,
	output logic mem_fwd_valid,
	output logic [cpu_cfg_pkg::reg_idx_w-1:0] mem_fwd_reg,
	output logic [cpu_cfg_pkg::word_w-1:0] mem_fwd_data,
	output logic wb_valid,
	output logic [cpu_cfg_pkg::reg_idx_w-1:0] wb_reg,
	output logic [cpu_cfg_pkg::word_w-1:0] wb_data,
	output logic hlt
);
	import cpu_cfg_pkg::*;

	logic [word_w-1:0] mem_data; // Value this instruction writes back

	// Data port, read data returns in the same cycle
	assign dmem_addr  = mem_addr;
	assign dmem_wdata = mem_store_data;
	assign dmem_we    = mem_valid && mem_mem_write;
	assign dmem_re    = mem_valid && mem_mem_to_reg;

	assign mem_data      = mem_mem_to_reg ? dmem_rdata : mem_result;
	assign mem_fwd_valid = mem_valid && mem_reg_write;
	assign mem_fwd_reg   = mem_rd;
	assign mem_fwd_data  = mem_data;

	// --------------------------------------------------
	// MEM/WB register and halt latch
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
			hlt      <= 1'b0;
		end else begin
			wb_valid <= mem_fwd_valid;
			hlt      <= hlt || (mem_valid && mem_halt); // Sticky until reset
		end
	end

	always_ff @(posedge clk) begin
		wb_reg  <= mem_rd;
		wb_data <= mem_data;
	end

endmodule

/* design/register_file.sv */
module register_file (
	input  logic clk,
	input  logic reset,
	input  logic [cpu_cfg_pkg::reg_idx_w-1:0] rd_idx_a,
	input  logic [cpu_cfg_pkg::reg_idx_w-1:0] rd_idx_b,
	input  logic wr_en,
	input  logic [cpu_cfg_pkg::reg_idx_w-1:0] wr_idx,
	input  logic [cpu_cfg_pkg::word_w-1:0] wr_data,
	output logic [cpu_cfg_pkg::word_w-1:0] rd_data_a,
	output logic [cpu_cfg_pkg::word_w-1:0] rd_data_b
);
	import cpu_cfg_pkg::*;

	logic [word_w-1:0] regs [reg_cnt];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < reg_cnt; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data; // r0 never written
		end
	end

	// Reads see a same-cycle write, r0 is hardwired zero
	assign rd_data_a = (rd_idx_a == '0) ? '0 :
	                   (wr_en && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
	assign rd_data_b = (rd_idx_b == '0) ? '0 :
	                   (wr_en && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

endmodule

/* list.f */
design/cpu_cfg_pkg.sv
design/isa_pkg.sv
design/register_file.sv
design/alu.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/cpu.sv
verification/cpu_asserts.sv
verification/cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the cpu testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f list.f --top-module cpu_tb -o cpu_tb_sim; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/cpu_tb_sim > "$LOG" 2>&1; then
	cat "$LOG"
	echo "Simulation exited with an error"
	exit 1
fi

cat "$LOG"

if grep -q "All tests passed" "$LOG"; then
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi

/* verification/cpu_asserts.sv */
module cpu_asserts (
	input logic clk,
	input logic reset,
	input logic hlt,
	input logic wb_valid,
	input logic [cpu_cfg_pkg::reg_idx_w-1:0] wb_reg,
	input logic dmem_we,
	input logic dmem_re
);
	import cpu_cfg_pkg::*;

	// Halt is sticky until reset
	hlt_sticky: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
		else $error("hlt dropped without reset");

	// r0 never shows up on the retire port
	no_r0_write: assert property (@(posedge clk) disable iff (reset) wb_valid |-> wb_reg != '0)
		else $error("retire to r0");

	no_rw_overlap: assert property (@(posedge clk) disable iff (reset) !(dmem_we && dmem_re))
		else $error("data read and write in the same cycle");

endmodule

bind cpu cpu_asserts i_cpu_asserts (.*);

/* verification/cpu_tb.sv */
module cpu_tb;
	import cpu_cfg_pkg::*;

	logic clk;
	logic reset;
	logic [word_w-1:0] imem_addr;
	logic [word_w-1:0] imem_data;
	logic [word_w-1:0] dmem_addr;
	logic [word_w-1:0] dmem_wdata;
	logic dmem_we;
	logic dmem_re;
	logic [word_w-1:0] dmem_rdata;
	logic wb_valid;
	logic [reg_idx_w-1:0] wb_reg;
	logic [word_w-1:0] wb_data;
	logic [word_w-1:0] pc_out;
	logic hlt;

	logic [word_w-1:0] imem [256]; // Word arrays indexed by byte address / 2
	logic [word_w-1:0] dmem [256];
	logic [word_w-1:0] ret_reg_q[$];  // Expected retires in program order
	logic [word_w-1:0] ret_data_q[$];
	logic [word_w-1:0] st_addr_q[$];  // Expected stores
	logic [word_w-1:0] st_data_q[$];
	int prog_words;
	logic vectors_loaded;
	logic [word_w-1:0] halt_pc;

	cpu i_dut (.*);

	always #5 clk = ~clk;

	// --------------------------------------------------
	// Failure reporting
	// --------------------------------------------------
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
	                           input logic [15:0] exp);
		if (got !== exp)
			report_failure($sformatf("FAIL %s: got %h expected %h", name, got, exp));
	endtask

	// --------------------------------------------------
	// Vector file reader
	// --------------------------------------------------
	task automatic load_vectors();
		int fd;
		int code;
		logic [7:0] tag;
		logic [15:0] a;
		logic [15:0] b;
		logic [8*160-1:0] line_buf;
		logic done;
		for (int i = 0; i < 256; i++) begin
			imem[i[7:0]] = '0;                   // add r0,r0,r0 acts as a nop
			dmem[i[7:0]] = {i[7:0], ~i[7:0]};    // Index-dependent fill
		end
		prog_words = 0;
		fd = $fopen("verification/program_vectors.txt", "r");
		if (fd == 0)
			report_failure("could not open verification/program_vectors.txt");
		done = 1'b0;
		while (!done) begin
			code = $fscanf(fd, " %c", tag);
			if (code != 1) begin
				done = 1'b1;                     // End of file
			end else if (tag == "#") begin
				code = $fgets(line_buf, fd);     // Skip comment line
			end else begin
				code = $fscanf(fd, "%h %h", a, b);
				if (code != 2)
					report_failure("malformed line in vectors file");
				case (tag)
					"P": begin
						imem[a[8:1]] = b;
						prog_words++;
					end
					"D": dmem[a[8:1]] = b;
					"W": begin
						ret_reg_q.push_back(a);
						ret_data_q.push_back(b);
					end
					"S": begin
						st_addr_q.push_back(a);
						st_data_q.push_back(b);
					end
					default: report_failure("unknown record tag in vectors file");
				endcase
			end
		end
		$fclose(fd);
	endtask

	// Memories answer a little after the edge for the address now present
	always @(posedge clk) begin
		#1;
		if (dmem_we)
			dmem[dmem_addr[8:1]] = dmem_wdata;
		imem_data = imem[imem_addr[8:1]];
		if (dmem_re === 1'b1)
			dmem_rdata = dmem[dmem_addr[8:1]];
		else
			dmem_rdata = '0; // Data only while a load asks for it
	end

	// --------------------------------------------------
	// Retire and store checkers sampled mid-cycle
	// --------------------------------------------------
	always @(negedge clk) begin
		if (reset === 1'b0 && wb_valid === 1'b1) begin
			if (ret_reg_q.size() == 0)
				report_failure("register write retired with no retire record left");
			check_value("wb_reg", {12'd0, wb_reg}, ret_reg_q.pop_front());
			check_value("wb_data", wb_data, ret_data_q.pop_front());
		end
		if (reset === 1'b0 && dmem_we === 1'b1) begin
			if (st_addr_q.size() == 0)
				report_failure("store seen with no store record left");
			check_value("dmem_addr", dmem_addr, st_addr_q.pop_front());
			check_value("dmem_wdata", dmem_wdata, st_data_q.pop_front());
		end
	end

	// Watchdog scaled by program length
	initial begin
		wait (vectors_loaded === 1'b1);
		repeat (20 * prog_words + 100) @(posedge clk);
		report_failure("timeout: halt never reached");
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		imem_data = '0;
		dmem_rdata = '0;
		vectors_loaded = 1'b0;
		load_vectors();
		vectors_loaded = 1'b1;
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;

		do
			@(negedge clk);
		while (hlt !== 1'b1);
		#1; // Let the checkers take this edge first
		if (ret_reg_q.size() != 0)
			report_failure($sformatf("halt with %0d retire records unmatched", ret_reg_q.size()));
		if (st_addr_q.size() != 0)
			report_failure($sformatf("halt with %0d store records unmatched", st_addr_q.size()));

		// Core must stay frozen after the halt
		halt_pc = pc_out;
		repeat (10) begin
			@(negedge clk);
			check_value("hlt", {15'd0, hlt}, 16'h0001);
			check_value("pc_out", pc_out, halt_pc);
			if (wb_valid !== 1'b0)
				report_failure("register write retired after halt");
		end
		$display("All tests passed");
		$finish;
	end

endmodule

/* verification/program_vectors.txt */
# P byte_addr word | D byte_addr word | W reg value | S byte_addr value
# All values hex, W and S records in retire order
P 0000 B105
P 0002 B203
P 0004 0312
P 0006 1431
P 0008 2532
P 000A 3654
P 000C 7753
P 000E A880
P 0010 5983
P 0012 4A14
P 0014 6B11
P 0016 BCFF
P 0018 AC7F
P 001A 0DCC
P 001C 1E81
P 001E B140
P 0020 8210
P 0022 0322
P 0024 9311
P 0026 8411
P 0028 1543
P 002A C202
P 002C B6EE
P 002E B7EE
P 0030 C001
P 0032 B611
P 0034 0768
P 0036 C602
P 0038 B9EE
P 003A BAEE
P 003C E900
P 003E BA46
P 0040 DEA0
P 0042 BBEE
P 0044 BCEE
P 0046 F000
P 0048 BDEE
D 0040 1234
W 1 0005
W 2 0003
W 3 0008
W 4 0003
W 5 000B
W 6 0003
W 7 000B
W 8 8000
W 9 F000
W A 0050
W B 8002
W C 00FF
W C 7FFF
W D 7FFF
W E 8000
W 1 0040
W 2 1234
W 3 2468
W 4 2468
W 5 0000
W 6 0011
W 7 8011
W 9 003E
W A 0046
S 0042 2468
